// File: ooo_core_top.f
rtl/ooo_pkg.sv
rtl/dispatch_if.sv
rtl/circular_queue.sv
rtl/rob.sv
rtl/inst_decode.sv
rtl/exec_lane.sv
rtl/arch_regfile.sv
rtl/ooo_core_top.sv
tb/ooo_core_top_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f ooo_core_top.f --top-module ooo_core_top_tb -o ooo_core_top_sim

out=$(./obj_dir/ooo_core_top_sim)
echo "$out"
echo "$out" | grep -q "TESTBENCH PASSED"

// File: tb/ooo_core_top_tb.sv
module ooo_core_top_tb;
    import ooo_pkg::*;

    localparam int SEED = 57;
    // 5 alu, 2 reorder, 8 full, 3 regfile and 30 random groups
    localparam int NUM_GROUPS = 48;
    localparam int TIMEOUT_CYCLES = 40 * NUM_GROUPS + 200;

    typedef struct {
        logic [4:0]  rd;
        logic [31:0] value;
        logic [31:0] order;
    } exp_t;

    logic clk;
    logic rst;
    logic in_valid;
    inst_word_t in_inst [SS];
    logic [4:0] rd_addr;
    logic rob_full;
    logic retire_valid [SS];
    logic [4:0] retire_rd [SS];
    logic [XLEN-1:0] retire_value [SS];
    logic [31:0] retire_order [SS];
    logic [31:0] rd_data;

    exp_t exp_q [$];
    logic [31:0] model_regs [32];
    inst_word_t grp [SS];
    logic [31:0] next_order;
    int errors;
    int checks;
    int cycle_cnt;
    logic full_seen;

    ooo_core_top dut (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_inst      (in_inst),
        .rd_addr      (rd_addr),
        .rob_full     (rob_full),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_value (retire_value),
        .retire_order (retire_order),
        .rd_data      (rd_data)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic logic [31:0] expected_result(input logic [2:0] code,
                                                    input logic [31:0] a,
                                                    input logic [31:0] b);
        case (code)
            3'd1:    return a - b;
            3'd2:    return a & b;
            3'd3:    return a | b;
            3'd4:    return a ^ b;
            3'd5:    return a * b;
            // add and the two unused codes
            default: return a + b;
        endcase
    endfunction

    function automatic inst_word_t make_inst(input logic [2:0] code, input logic [4:0] rd);
        inst_word_t w;
        w.op = code;
        w.rd = rd;
        w.a  = OPND_W'($urandom_range(0, 4095));
        w.b  = OPND_W'($urandom_range(0, 4095));
        return w;
    endfunction

    // drives grp, holds it until rob_full is low, then records the expected retirements
    task automatic issue_group();
        exp_t e;
        @(posedge clk);
        in_valid <= 1'b1;
        for (int i = 0; i < SS; i++) begin
            in_inst[i] <= grp[i];
        end
        @(negedge clk);
        while (rob_full) begin
            @(negedge clk);
        end
        for (int i = 0; i < SS; i++) begin
            e.rd    = grp[i].rd;
            e.value = expected_result(grp[i].op, 32'(grp[i].a), 32'(grp[i].b));
            e.order = next_order;
            next_order = next_order + 1;
            exp_q.push_back(e);
        end
    endtask

    task automatic stop_issue();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic check_retire(input int k);
        exp_t e;
        assert (exp_q.size() != 0) else begin
            errors++;
            $display("slot %0d retired an instruction that was never accepted", k);
        end
        if (exp_q.size() != 0) begin
            e = exp_q.pop_front();
            checks++;
            assert (retire_rd[k] == e.rd) else begin
                errors++;
                $display("FAILED retire_rd[%0d]: got %h expected %h", k, retire_rd[k], e.rd);
            end
            assert (retire_value[k] == e.value) else begin
                errors++;
                $display("FAILED retire_value[%0d]: got %h expected %h",
                         k, retire_value[k], e.value);
            end
            assert (retire_order[k] == e.order) else begin
                errors++;
                $display("FAILED retire_order[%0d]: got %h expected %h",
                         k, retire_order[k], e.order);
            end
            if (e.rd != 5'd0) begin
                model_regs[e.rd] = e.value;
            end
        end
    endtask

    // retire outputs settle during the cycle, so they are sampled at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (rob_full) begin
                full_seen = 1'b1;
            end
            for (int k = 0; k < SS; k++) begin
                if (retire_valid[k]) begin
                    check_retire(k);
                end
            end
        end
    end

    task automatic check_regs();
        for (int r = 0; r < 32; r++) begin
            @(posedge clk);
            rd_addr <= 5'(r);
            @(negedge clk);
            assert (rd_data == model_regs[r]) else begin
                errors++;
                $display("FAILED rd_data x%0d: got %h expected %h", r, rd_data, model_regs[r]);
            end
        end
    endtask

    task automatic alu_group_test();
        logic [2:0] alu_ops [5];
        alu_ops = '{3'd0, 3'd1, 3'd2, 3'd3, 3'd4};
        for (int n = 0; n < 5; n++) begin
            grp[0] = make_inst(alu_ops[n], 5'(2 * n + 1));
            grp[1] = make_inst(alu_ops[n], 5'(2 * n + 2));
            issue_group();
        end
        stop_issue();
        wait_drain();
    endtask

    task automatic mul_reorder_test();
        // the mul finishes after the younger alu results
        grp[0] = make_inst(3'd5, 5'd11);
        grp[1] = make_inst(3'd0, 5'd12);
        issue_group();
        grp[0] = make_inst(3'd1, 5'd13);
        grp[1] = make_inst(3'd4, 5'd14);
        issue_group();
        stop_issue();
        wait_drain();
    endtask

    task automatic rob_full_test();
        full_seen = 1'b0;
        for (int n = 0; n < 8; n++) begin
            grp[0] = make_inst(3'd5, 5'(15 + n));
            grp[1] = make_inst(3'd5, 5'(16 + n));
            issue_group();
        end
        stop_issue();
        wait_drain();
        assert (full_seen) else begin
            errors++;
            $display("rob_full never rose during back to back multiply groups");
        end
        assert (!rob_full) else begin
            errors++;
            $display("rob_full still high after all instructions retired");
        end
    endtask

    task automatic regfile_state_test();
        grp[0] = make_inst(3'd0, 5'd5);
        grp[1] = make_inst(3'd4, 5'd5);
        issue_group();
        grp[0] = make_inst(3'd3, 5'd0);
        grp[1] = make_inst(3'd2, 5'd7);
        issue_group();
        // both retire in the same cycle once the mul completes
        grp[0] = make_inst(3'd5, 5'd9);
        grp[1] = make_inst(3'd0, 5'd9);
        issue_group();
        stop_issue();
        wait_drain();
        check_regs();
    endtask

    task automatic random_mix_test();
        for (int n = 0; n < 30; n++) begin
            for (int i = 0; i < SS; i++) begin
                grp[i] = make_inst(3'($urandom_range(0, 7)), 5'($urandom_range(0, 31)));
            end
            issue_group();
        end
        stop_issue();
        wait_drain();
        check_regs();
    endtask

    initial begin
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
        end
        $display("timeout after %0d cycles with %0d retirements outstanding",
                 cycle_cnt, exp_q.size());
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        clk = 1'b0;
        rst = 1'b1;
        in_valid = 1'b0;
        rd_addr = 5'd0;
        for (int i = 0; i < SS; i++) begin
            in_inst[i] = '0;
        end
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        next_order = '0;
        errors = 0;
        checks = 0;
        cycle_cnt = 0;
        full_seen = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!rob_full && !retire_valid[0] && !retire_valid[1]) else begin
            errors++;
            $display("rob_full or retire_valid high after reset");
        end

        alu_group_test();
        mul_reorder_test();
        rob_full_test();
        regfile_state_test();
        random_mix_test();

        $display("retirements checked: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: rtl/ooo_core_top.sv
module ooo_core_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    input  ooo_pkg::inst_word_t       in_inst [ooo_pkg::SS],
    input  logic [4:0]                rd_addr,
    output logic                      rob_full,
    output logic                      retire_valid [ooo_pkg::SS],
    output logic [4:0]                retire_rd [ooo_pkg::SS],
    output logic [ooo_pkg::XLEN-1:0]  retire_value [ooo_pkg::SS],
    output logic [31:0]               retire_order [ooo_pkg::SS],
    output logic [31:0]               rd_data
);
    import ooo_pkg::*;

    dispatch_if dsp ();

    // port 2i is the alu path of lane i, 2i+1 its mul path
    cdb_t cdb [NUM_CDB];

    inst_decode u_decode (
        .in_valid (in_valid),
        .in_inst  (in_inst),
        .rob_full (rob_full),
        .dsp      (dsp)
    );

    for (genvar i = 0; i < SS; i++) begin : g_lane
        exec_lane #(.LANE(i)) u_lane (
            .clk     (clk),
            .rst     (rst),
            .dsp     (dsp),
            .alu_cdb (cdb[2*i]),
            .mul_cdb (cdb[2*i+1])
        );
    end

    rob u_rob (
        .clk          (clk),
        .rst          (rst),
        .cdb          (cdb),
        .dsp          (dsp),
        .rob_full     (rob_full),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_value (retire_value),
        .retire_order (retire_order)
    );

    arch_regfile u_regfile (
        .clk          (clk),
        .rst          (rst),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_value (retire_value),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data)
    );

endmodule

// File: rtl/arch_regfile.sv
module arch_regfile (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      retire_valid [ooo_pkg::SS],
    input  logic [4:0]                retire_rd [ooo_pkg::SS],
    input  logic [ooo_pkg::XLEN-1:0]  retire_value [ooo_pkg::SS],
    input  logic [4:0]                rd_addr,
    output logic [ooo_pkg::XLEN-1:0]  rd_data
);
    import ooo_pkg::*;

    logic [XLEN-1:0] regs [32];

    // later slots are younger, so their write lands last
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < 32; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int k = 0; k < SS; k++) begin
                if (retire_valid[k] && retire_rd[k] != 5'd0) begin
                    regs[retire_rd[k]] <= retire_value[k];
                end
            end
        end
    end

    // x0 is never written and reads back as zero
    assign rd_data = regs[rd_addr];

endmodule

// File: rtl/exec_lane.sv
module exec_lane #(
    parameter int LANE = 0
) (
    input  logic           clk,
    input  logic           rst,
    dispatch_if.lane       dsp,
    output ooo_pkg::cdb_t  alu_cdb,
    output ooo_pkg::cdb_t  mul_cdb
);
    import ooo_pkg::*;

    exec_req_t req;
    logic alu_go;
    logic mul_go;
    logic [XLEN-1:0] alu_res;

    logic alu_valid;
    logic [ROB_ID_W-1:0] alu_id;
    logic [XLEN-1:0] alu_val;

    // mul pipeline stages hold the operands, then the product, then the result
    logic m1_valid, m2_valid, m3_valid;
    logic [ROB_ID_W-1:0] m1_id, m2_id, m3_id;
    logic [XLEN-1:0] m1_a, m1_b, m2_prod, m3_val;

    if (LANE >= SS) begin : g_lane_chk
        $error("exec_lane: LANE out of range");
    end

    assign req    = dsp.reqs[LANE];
    assign alu_go = dsp.valid && req.op != OP_MUL;
    assign mul_go = dsp.valid && req.op == OP_MUL;

    always_comb begin
        case (req.op)
            OP_SUB:  alu_res = req.a - req.b;
            OP_AND:  alu_res = req.a & req.b;
            OP_OR:   alu_res = req.a | req.b;
            OP_XOR:  alu_res = req.a ^ req.b;
            default: alu_res = req.a + req.b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_valid <= 1'b0;
            m1_valid  <= 1'b0;
            m2_valid  <= 1'b0;
            m3_valid  <= 1'b0;
        end else begin
            alu_valid <= alu_go;
            m1_valid  <= mul_go;
            m2_valid  <= m1_valid;
            m3_valid  <= m2_valid;
        end
    end

    always_ff @(posedge clk) begin
        alu_id  <= req.rob_id;
        alu_val <= alu_res;
        m1_id   <= req.rob_id;
        m1_a    <= req.a;
        m1_b    <= req.b;
        m2_id   <= m1_id;
        m2_prod <= m1_a * m1_b;
        m3_id   <= m2_id;
        m3_val  <= m2_prod;
    end

    assign alu_cdb = '{valid: alu_valid, rob_id: alu_id, value: alu_val};
    assign mul_cdb = '{valid: m3_valid, rob_id: m3_id, value: m3_val};

    // an id stays allocated until retirement, so the two ports cannot share one
    assert property (@(posedge clk) disable iff (rst)
        !(alu_valid && m3_valid && alu_id == m3_id))
        else $error("exec_lane %0d: alu and mul both report id %0d", LANE, alu_id);

endmodule

// File: rtl/inst_decode.sv
module inst_decode (
    input  logic                 in_valid,
    input  ooo_pkg::inst_word_t  in_inst [ooo_pkg::SS],
    input  logic                 rob_full,
    dispatch_if.dec              dsp
);
    import ooo_pkg::*;

    op_e op [SS];

    // unknown codes fall back to add
    function automatic op_e decode_op(input logic [2:0] code);
        op_e res;
        case (code)
            OP_SUB:  res = OP_SUB;
            OP_AND:  res = OP_AND;
            OP_OR:   res = OP_OR;
            OP_XOR:  res = OP_XOR;
            OP_MUL:  res = OP_MUL;
            default: res = OP_ADD;
        endcase
        return res;
    endfunction

    always_comb begin
        for (int i = 0; i < SS; i++) begin
            op[i] = decode_op(in_inst[i].op);
        end
    end

    // the whole group goes in together or not at all
    assign dsp.valid = in_valid && !rob_full;

    always_comb begin
        for (int i = 0; i < SS; i++) begin
            dsp.entries[i].rd    = in_inst[i].rd;
            dsp.entries[i].value = '0;
            dsp.entries[i].done  = 1'b0;
            dsp.entries[i].op    = op[i];

            // operands are zero-extended immediates
            dsp.reqs[i].op     = op[i];
            dsp.reqs[i].a      = XLEN'(in_inst[i].a);
            dsp.reqs[i].b      = XLEN'(in_inst[i].b);
            dsp.reqs[i].rob_id = dsp.base_id + ROB_ID_W'(i);
        end
    end

endmodule

// File: rtl/rob.sv
module rob (
    input  logic                          clk,
    input  logic                          rst,
    input  ooo_pkg::cdb_t                 cdb [ooo_pkg::NUM_CDB],
    dispatch_if.rob                       dsp,
    output logic                          rob_full,
    output logic                          retire_valid [ooo_pkg::SS],
    output logic [4:0]                    retire_rd [ooo_pkg::SS],
    output logic [ooo_pkg::XLEN-1:0]      retire_value [ooo_pkg::SS],
    output logic [31:0]                   retire_order [ooo_pkg::SS]
);
    import ooo_pkg::*;

    rob_entry_t head_entries [SS];
    logic head_present [SS];
    logic [ROB_ID_W-1:0] tail;
    logic [$clog2(SS+1)-1:0] pop_count;

    logic mark_valid [NUM_CDB];
    logic [ROB_ID_W-1:0] mark_id [NUM_CDB];
    logic [XLEN-1:0] mark_value [NUM_CDB];

    // running count of retired instructions
    logic [31:0] order_cnt;
    logic [SS:0] ready_prefix;

    // occupancy derived from the order counter for the mark check
    logic [ROB_ID_W-1:0] head_id;
    logic [ROB_ID_W-1:0] used;
    logic mark_ok [NUM_CDB];

    circular_queue #(
        .QUEUE_TYPE (rob_entry_t),
        .DEPTH      (ROB_DEPTH),
        .WIDTH      (SS)
    ) u_queue (
        .clk          (clk),
        .rst          (rst),
        .push         (dsp.valid),
        .in           (dsp.entries),
        .pop_count    (pop_count),
        .mark_valid   (mark_valid),
        .mark_id      (mark_id),
        .mark_value   (mark_value),
        .head_entries (head_entries),
        .head_present (head_present),
        .tail         (tail),
        .full         (rob_full)
    );

    assign dsp.base_id = tail;

    always_comb begin
        for (int c = 0; c < NUM_CDB; c++) begin
            mark_valid[c] = cdb[c].valid;
            mark_id[c]    = cdb[c].rob_id;
            mark_value[c] = cdb[c].value;
        end
    end

    // slot k retires only if every older slot retires too
    always_comb begin
        ready_prefix[0] = 1'b1;
        pop_count = '0;
        for (int k = 0; k < SS; k++) begin
            ready_prefix[k+1] = ready_prefix[k] && head_present[k] && head_entries[k].done;
            retire_valid[k] = ready_prefix[k+1];
            retire_rd[k]    = head_entries[k].rd;
            retire_value[k] = head_entries[k].value;
            retire_order[k] = order_cnt + 32'(k);
            if (ready_prefix[k+1]) begin
                pop_count = pop_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            order_cnt <= '0;
        end else begin
            order_cnt <= order_cnt + 32'(pop_count);
        end
    end

    // ids are handed out in order from 0, so the head id is the low order bits
    assign head_id = order_cnt[ROB_ID_W-1:0];
    assign used    = tail - head_id;

    always_comb begin
        for (int c = 0; c < NUM_CDB; c++) begin
            mark_ok[c] = (rob_full && used == '0) ||
                         (ROB_ID_W'(cdb[c].rob_id - head_id) < used);
        end
    end

    for (genvar c = 0; c < NUM_CDB; c++) begin : g_mark_chk
        assert property (@(posedge clk) disable iff (rst) cdb[c].valid |-> mark_ok[c])
            else $error("rob: cdb port %0d marks absent id %0d", c, cdb[c].rob_id);
    end

endmodule

// File: rtl/circular_queue.sv
module circular_queue #(
    parameter type QUEUE_TYPE = ooo_pkg::rob_entry_t,
    parameter int  DEPTH = 8,
    parameter int  WIDTH = 2
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         push,
    input  QUEUE_TYPE                    in [WIDTH],
    input  logic [$clog2(WIDTH+1)-1:0]   pop_count,
    input  logic                         mark_valid [ooo_pkg::NUM_CDB],
    input  logic [$clog2(DEPTH)-1:0]     mark_id [ooo_pkg::NUM_CDB],
    input  logic [ooo_pkg::XLEN-1:0]     mark_value [ooo_pkg::NUM_CDB],
    output QUEUE_TYPE                    head_entries [WIDTH],
    output logic                         head_present [WIDTH],
    output logic [$clog2(DEPTH)-1:0]     tail,
    output logic                         full
);
    import ooo_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    QUEUE_TYPE mem [DEPTH];
    logic [PTR_W-1:0] head;
    logic [CNT_W-1:0] count;

    // pointers wrap by truncation
    if ((1 << PTR_W) != DEPTH) begin : g_depth_chk
        $error("circular_queue: DEPTH must be a power of two");
    end

    // full means a whole group of WIDTH no longer fits
    assign full = count > CNT_W'(DEPTH - WIDTH);

    always_comb begin
        for (int i = 0; i < WIDTH; i++) begin
            head_entries[i] = mem[head + PTR_W'(i)];
            head_present[i] = count > CNT_W'(i);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head <= head + PTR_W'(pop_count);
            if (push) begin
                tail <= tail + PTR_W'(WIDTH);
            end
            count <= count + (push ? CNT_W'(WIDTH) : '0) - CNT_W'(pop_count);
        end
    end

    // pushed slots are free, marked slots are occupied, so the two never collide
    always_ff @(posedge clk) begin
        if (push) begin
            for (int i = 0; i < WIDTH; i++) begin
                mem[tail + PTR_W'(i)] <= in[i];
            end
        end
        for (int c = 0; c < NUM_CDB; c++) begin
            if (mark_valid[c]) begin
                mem[mark_id[c]].done  <= 1'b1;
                mem[mark_id[c]].value <= mark_value[c];
            end
        end
    end

    // the producer is expected to hold off on full
    assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else $error("circular_queue: push while full");

    assert property (@(posedge clk) disable iff (rst) CNT_W'(pop_count) <= count)
        else $error("circular_queue: pop of %0d with %0d present", pop_count, count);

endmodule

// File: rtl/dispatch_if.sv
interface dispatch_if;
    import ooo_pkg::*;

    // group strobe already masked by rob_full
    logic valid;
    // slot i of the group gets base_id + i
    logic [ROB_ID_W-1:0] base_id;
    rob_entry_t entries [SS];
    exec_req_t  reqs [SS];

    modport dec (
        output valid,
        output entries,
        output reqs,
        input  base_id
    );

    modport rob (input valid, input entries, output base_id);

    modport lane (input valid, input reqs);

endinterface

// File: rtl/ooo_pkg.sv
package ooo_pkg;

    // dispatch group size and retire bandwidth
    localparam int SS = 2;

    localparam int ROB_DEPTH = 8;
    localparam int ROB_ID_W = $clog2(ROB_DEPTH);

    // one alu port and one mul port per lane
    localparam int NUM_CDB = 2 * SS;

    localparam int XLEN = 32;
    localparam int OPND_W = 12;

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_MUL = 3'd5
    } op_e;

    // raw instruction word with op in the top bits
    typedef struct packed {
        logic [2:0]        op;
        logic [4:0]        rd;
        logic [OPND_W-1:0] a;
        logic [OPND_W-1:0] b;
    } inst_word_t;

    typedef struct packed {
        logic [4:0]      rd;
        logic [XLEN-1:0] value;
        logic            done;
        op_e             op;
    } rob_entry_t;

    typedef struct packed {
        op_e                 op;
        logic [XLEN-1:0]     a;
        logic [XLEN-1:0]     b;
        logic [ROB_ID_W-1:0] rob_id;
    } exec_req_t;

    // one common data bus port
    typedef struct packed {
        logic                valid;
        logic [ROB_ID_W-1:0] rob_id;
        logic [XLEN-1:0]     value;
    } cdb_t;

endpackage
